// ==== verilog.f ====
+incdir+verilog
verilog/uart_line_pkg.sv
verilog/uart_stream_pkg.sv
verilog/uart_rx.sv
verilog/uart_byte_fifo.sv
verilog/uart_tx.sv
verilog/uart_echo_top.sv
tb/uart_echo_props.sv
tb/uart_echo_tb.sv

// ==== Makefile ====
TOP := uart_echo_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) \
		-f verilog.f -Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "^sim passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tb/uart_echo_tb.sv ====
// each test starts with an empty fifo and an idle line; timeouts count as errors and the run goes on
`timescale 1ns/10ps
`include "uart_defines.svh"

module uart_echo_tb;

   localparam int clks_per_bit = `UART_CLKS_PER_BIT;
   localparam int fifo_depth   = `UART_FIFO_DEPTH;

   // one frame put on i_rx and the conditions it was sent under
   typedef struct packed {
      logic [7:0] data;
      logic       stop_ok;
      logic       paused;
   } sent_frame_t;

   typedef logic [7:0] byte_q_t[$];

   logic                         i_clk = 1'b0;
   logic                         i_nrst;
   logic                         i_rx;
   logic                         i_tx_pause;
   logic                         o_tx;
   uart_line_pkg::line_status_t  o_status;

   byte_q_t rcv_q;
   byte_q_t exp_q;
   int      err_cnt = 0;
   int      test_cnt = 0;
   int      failed_tests = 0;
   int      frame_err_cnt = 0;
   int      overrun_cnt = 0;
   logic    full_seen = 1'b0;
   logic    tx_low_paused = 1'b0;

   uart_echo_top dut0 (
      .i_clk      (i_clk),
      .i_nrst     (i_nrst),
      .i_rx       (i_rx),
      .i_tx_pause (i_tx_pause),
      .o_tx       (o_tx),
      .o_status   (o_status)
   );

   always #10 i_clk = ~i_clk;

   //////////////////////////////////////////////////////////////////////
   // expected echo
   //////////////////////////////////////////////////////////////////////

   // bad stop bits vanish, and a paused channel keeps only what the fifo holds
   function automatic byte_q_t expected_echo(input sent_frame_t frames[$]);
      byte_q_t echo;
      int      held;
      held = 0;
      foreach (frames[i]) begin
         if (frames[i].stop_ok && (!frames[i].paused || held < fifo_depth)) begin
            echo.push_back(frames[i].data);
            if (frames[i].paused) begin
               held++;
            end
         end
      end
      return echo;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // line driver and monitor
   //////////////////////////////////////////////////////////////////////

   task automatic drive_frame(input logic [7:0] data, input logic stop_bit);
      logic [9:0] bits;
      bits = {stop_bit, data, 1'b0};
      for (int b = 0; b < 10; b++) begin
         i_rx = bits[0];
         bits = bits >> 1;
         repeat (clks_per_bit) @(negedge i_clk);
      end
      // a low stop bit needs an idle bit so the next start edge is seen
      if (!stop_bit) begin
         i_rx = 1'b1;
         repeat (clks_per_bit) @(negedge i_clk);
      end
   endtask

   task automatic send_frames(input sent_frame_t frames[$]);
      byte_q_t echo;
      echo = expected_echo(frames);
      foreach (echo[i]) begin
         exp_q.push_back(echo[i]);
      end
      foreach (frames[i]) begin
         drive_frame(frames[i].data, frames[i].stop_ok);
      end
   endtask

   // every sample in a bit window must match, so bit edges sit exactly on the grid
   initial begin : line_monitor
      logic [9:0] frame_bits;
      logic       first;
      logic       bad_width;
      forever begin
         @(negedge i_clk);
         if (i_nrst && !o_tx) begin
            bad_width = 1'b0;
            for (int b = 0; b < 10; b++) begin
               first = o_tx;
               for (int s = 0; s < clks_per_bit; s++) begin
                  if (o_tx != first) begin
                     bad_width = 1'b1;
                  end
                  if (s == clks_per_bit / 2) begin
                     frame_bits = {o_tx, frame_bits[9:1]};
                  end
                  @(negedge i_clk);
               end
            end
            if (bad_width) begin
               $display("%0t: echoed frame has a bit off its bit period", $time);
               err_cnt++;
            end
            if (!frame_bits[9]) begin
               $display("Fail %0t: o_tx stop bit expected 1 got 0", $time);
               err_cnt++;
            end
            rcv_q.push_back(frame_bits[8:1]);
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // comparison and status counting
   //////////////////////////////////////////////////////////////////////

   always @(negedge i_clk) begin : compare_echo
      logic [7:0] got;
      logic [7:0] want;
      if (rcv_q.size() != 0) begin
         got = rcv_q.pop_front();
         if (exp_q.size() == 0) begin
            $display("%0t: o_tx echoed 0x%02h that was never expected", $time, got);
            err_cnt++;
         end else begin
            want = exp_q.pop_front();
            if (got != want) begin
               $display("Fail %0t: o_tx byte expected 0x%02h got 0x%02h", $time, want, got);
               err_cnt++;
            end
         end
      end
   end

   always @(negedge i_clk) begin
      if (i_nrst) begin
         if (o_status.frame_err) begin
            frame_err_cnt++;
         end
         if (o_status.overrun) begin
            overrun_cnt++;
         end
         if (o_status.fifo_full) begin
            full_seen = 1'b1;
         end
         if (i_tx_pause && !o_tx) begin
            tx_low_paused = 1'b1;
         end
      end
   end

   task automatic wait_echo_drained();
      int cycles;
      int limit;
      cycles = 0;
      limit  = (exp_q.size() + 2) * 12 * clks_per_bit;
      while ((exp_q.size() != 0 || rcv_q.size() != 0) && cycles < limit) begin
         @(negedge i_clk);
         cycles++;
      end
      if (exp_q.size() != 0) begin
         $display("%0t: timed out with %0d echoed bytes missing", $time, exp_q.size());
         err_cnt++;
         exp_q.delete();
      end
      // quiet time so a stray extra frame still gets caught
      repeat (12 * clks_per_bit) @(negedge i_clk);
   endtask

   task automatic check_count(input string sig, input int want, input int got);
      if (want != got) begin
         $display("Fail %0t: %s pulses expected %0d got %0d", $time, sig, want, got);
         err_cnt++;
      end
   endtask

   task automatic report_test(input string name, input int errs_before);
      test_cnt++;
      if (err_cnt == errs_before) begin
         $display("test %0d %s: ok", test_cnt, name);
      end else begin
         failed_tests++;
         $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - errs_before);
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // test sequence
   //////////////////////////////////////////////////////////////////////

   initial begin
      sent_frame_t frames[$];
      int          errs;
      int          fe0;
      int          ov0;
      i_nrst     = 1'b0;
      i_rx       = 1'b1;
      i_tx_pause = 1'b0;
      void'($urandom(32'h6b3f01d7));
      repeat (3) @(negedge i_clk);
      i_nrst = 1'b1;

      errs = err_cnt;
      for (int c = 0; c < 20 * clks_per_bit && err_cnt == errs; c++) begin
         @(negedge i_clk);
         if (o_tx !== 1'b1 || o_status !== '0) begin
            $display("Fail %0t: o_tx,o_status expected 1,000 got %b,%b", $time, o_tx, o_status);
            err_cnt++;
         end
      end
      report_test("idle after reset", errs);

      // alternating bits make every bit edge visible
      errs = err_cnt;
      frames.delete();
      frames.push_back('{data: 8'h55, stop_ok: 1'b1, paused: 1'b0});
      send_frames(frames);
      wait_echo_drained();
      report_test("single byte", errs);

      errs = err_cnt;
      ov0  = overrun_cnt;
      frames.delete();
      for (int n = 0; n < 20; n++) begin
         frames.push_back('{data: 8'($urandom), stop_ok: 1'b1, paused: 1'b0});
      end
      send_frames(frames);
      wait_echo_drained();
      check_count("o_status.overrun", 0, overrun_cnt - ov0);
      report_test("random burst", errs);

      errs = err_cnt;
      fe0  = frame_err_cnt;
      frames.delete();
      frames.push_back('{data: 8'hc3, stop_ok: 1'b0, paused: 1'b0});
      frames.push_back('{data: 8'h3a, stop_ok: 1'b1, paused: 1'b0});
      send_frames(frames);
      wait_echo_drained();
      check_count("o_status.frame_err", 1, frame_err_cnt - fe0);
      report_test("framing error", errs);

      errs          = err_cnt;
      ov0           = overrun_cnt;
      full_seen     = 1'b0;
      tx_low_paused = 1'b0;
      i_tx_pause    = 1'b1;
      frames.delete();
      for (int n = 0; n < 10; n++) begin
         frames.push_back('{data: 8'($urandom), stop_ok: 1'b1, paused: 1'b1});
      end
      send_frames(frames);
      repeat (2 * clks_per_bit) @(negedge i_clk);
      check_count("o_status.overrun", 2, overrun_cnt - ov0);
      if (!full_seen) begin
         $display("Fail %0t: o_status.fifo_full expected 1 got 0", $time);
         err_cnt++;
      end
      if (tx_low_paused) begin
         $display("%0t: o_tx left idle while the transmitter was paused", $time);
         err_cnt++;
      end
      i_tx_pause = 1'b0;
      wait_echo_drained();
      report_test("paused overrun", errs);

      $display("tests %0d, failed %0d, errors %0d", test_cnt, failed_tests, err_cnt);
      if (err_cnt == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

// ==== tb/uart_echo_props.sv ====
// checks reach the transmitter state and fifo count by hierarchy, so the instance names must stay
`timescale 1ns/10ps
`include "uart_defines.svh"

module uart_echo_props (
   input logic                         i_clk,
   input logic                         i_nrst,
   input logic                         i_tx,
   input uart_line_pkg::line_status_t  i_status,
   input logic                         i_rx_valid,
   input logic                         i_rx_ready,
   input uart_line_pkg::tx_state_e     i_tx_state,
   input uart_stream_pkg::fifo_count_t i_fifo_count
);

   // idle line must be high
   tx_idle_high: assert property (@(posedge i_clk) disable iff (!i_nrst)
      (i_tx_state == uart_line_pkg::TX_IDLE) |-> i_tx)
      else $error("o_tx low while the transmitter is idle");

   // status pulses last one cycle
   frame_err_pulse: assert property (@(posedge i_clk) disable iff (!i_nrst)
      i_status.frame_err |=> !i_status.frame_err)
      else $error("frame_err held longer than one cycle");

   overrun_pulse: assert property (@(posedge i_clk) disable iff (!i_nrst)
      i_status.overrun |=> !i_status.overrun)
      else $error("overrun held longer than one cycle");

   // a refused byte leaves the occupancy no higher than before
   no_push_when_full: assert property (@(posedge i_clk) disable iff (!i_nrst)
      (i_rx_valid && !i_rx_ready) |=> (i_fifo_count <= $past(i_fifo_count)))
      else $error("fifo took a push while full");

   count_in_range: assert property (@(posedge i_clk) disable iff (!i_nrst)
      i_fifo_count <= uart_stream_pkg::fifo_count_t'(`UART_FIFO_DEPTH))
      else $error("fifo occupancy above its depth");

endmodule

bind uart_echo_top uart_echo_props props0 (
   .i_clk        (i_clk),
   .i_nrst       (i_nrst),
   .i_tx         (o_tx),
   .i_status     (o_status),
   .i_rx_valid   (rx_valid),
   .i_rx_ready   (rx_ready),
   .i_tx_state   (u_tx.state),
   .i_fifo_count (u_fifo.count)
);

// ==== verilog/uart_echo_top.sv ====
// echo channel, rx into fifo into tx; bytes received while the fifo is full are dropped
`timescale 1ns/10ps

module uart_echo_top (
   input  logic                        i_clk,
   input  logic                        i_nrst,
   input  logic                        i_rx,
   input  logic                        i_tx_pause,
   output logic                        o_tx,
   output uart_line_pkg::line_status_t o_status
);

   // receiver to fifo
   logic                        rx_valid;
   logic                        rx_ready;
   uart_stream_pkg::data_byte_t rx_data;

   // fifo to transmitter
   logic                        q_valid;
   logic                        q_ready;
   uart_stream_pkg::data_byte_t q_data;

   logic                        frame_err;
   logic                        overrun;
   logic                        fifo_full;

   uart_rx u_rx (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_rx        (i_rx),
      .o_valid     (rx_valid),
      .o_data      (rx_data),
      .i_ready     (rx_ready),
      .o_frame_err (frame_err),
      .o_overrun   (overrun)
   );

   uart_byte_fifo u_fifo (
      .i_clk        (i_clk),
      .i_nrst       (i_nrst),
      .i_push_valid (rx_valid),
      .i_push_data  (rx_data),
      .o_push_ready (rx_ready),
      .o_pop_valid  (q_valid),
      .o_pop_data   (q_data),
      .i_pop_ready  (q_ready),
      .o_full       (fifo_full)
   );

   uart_tx u_tx (
      .i_clk   (i_clk),
      .i_nrst  (i_nrst),
      .i_valid (q_valid),
      .i_data  (q_data),
      .o_ready (q_ready),
      .i_pause (i_tx_pause),
      .o_tx    (o_tx)
   );

   assign o_status = '{frame_err: frame_err, overrun: overrun, fifo_full: fifo_full};

endmodule

// ==== verilog/uart_tx.sv ====
// 8N1 transmitter at one fixed rate; pause only holds off new frames, never one in flight
`timescale 1ns/10ps
`include "uart_defines.svh"

module uart_tx (
   input  logic                        i_clk,
   input  logic                        i_nrst,
   input  logic                        i_valid,
   input  uart_stream_pkg::data_byte_t i_data,
   output logic                        o_ready,
   input  logic                        i_pause,
   output logic                        o_tx
);

   uart_line_pkg::tx_state_e              state;
   logic [$clog2(`UART_CLKS_PER_BIT)-1:0] baud_cnt;
   logic [$clog2(`UART_CLKS_PER_BIT)-1:0] baud_next;
   logic                                  full_bit;
   logic [2:0]                            bit_idx;
   uart_stream_pkg::data_byte_t           tx_byte;
   logic                                  tx_q;

   //////////////////////////////////////////////////////////////////////
   // byte acceptance
   //////////////////////////////////////////////////////////////////////

   // pops the fifo head in the one idle cycle that sees it
   assign o_ready = (state == uart_line_pkg::TX_IDLE) && i_valid && !i_pause;

   // hold the byte locally, the fifo head moves on after the pop
   always_ff @(posedge i_clk) begin
      if (o_ready) begin
         tx_byte <= i_data;
      end
   end

   assign baud_next = baud_cnt + ($clog2(`UART_CLKS_PER_BIT))'(1);
   assign full_bit  = (baud_cnt == ($clog2(`UART_CLKS_PER_BIT))'(`UART_CLKS_PER_BIT - 1));

   //////////////////////////////////////////////////////////////////////
   // frame state machine and line driver
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state    <= uart_line_pkg::TX_IDLE;
         baud_cnt <= '0;
         bit_idx  <= '0;
         tx_q     <= 1'b1;
      end else begin
         case (state)
            uart_line_pkg::TX_IDLE: begin
               baud_cnt <= '0;
               if (o_ready) begin
                  state <= uart_line_pkg::TX_START;
                  tx_q  <= 1'b0;
               end
            end
            uart_line_pkg::TX_START: begin
               if (full_bit) begin
                  baud_cnt <= '0;
                  bit_idx  <= '0;
                  tx_q     <= tx_byte[0];
                  state    <= uart_line_pkg::TX_DATA;
               end else begin
                  baud_cnt <= baud_next;
               end
            end
            uart_line_pkg::TX_DATA: begin
               if (full_bit) begin
                  baud_cnt <= '0;
                  if (bit_idx == 3'd7) begin
                     tx_q  <= 1'b1;
                     state <= uart_line_pkg::TX_STOP;
                  end else begin
                     bit_idx <= bit_idx + 3'd1;
                     tx_q    <= tx_byte[bit_idx + 3'd1];
                  end
               end else begin
                  baud_cnt <= baud_next;
               end
            end
            uart_line_pkg::TX_STOP: begin
               // line stays high through stop and into idle
               if (full_bit) begin
                  baud_cnt <= '0;
                  state    <= uart_line_pkg::TX_IDLE;
               end else begin
                  baud_cnt <= baud_next;
               end
            end
            default: state <= uart_line_pkg::TX_IDLE;
         endcase
      end
   end

   assign o_tx = tx_q;

endmodule

// ==== verilog/uart_byte_fifo.sv ====
// synchronous byte fifo, depth set by the defines header; no push is taken while full
`timescale 1ns/10ps
`include "uart_defines.svh"

module uart_byte_fifo (
   input  logic                        i_clk,
   input  logic                        i_nrst,
   input  logic                        i_push_valid,
   input  uart_stream_pkg::data_byte_t i_push_data,
   output logic                        o_push_ready,
   output logic                        o_pop_valid,
   output uart_stream_pkg::data_byte_t o_pop_data,
   input  logic                        i_pop_ready,
   output logic                        o_full
);

   uart_stream_pkg::data_byte_t         mem [`UART_FIFO_DEPTH];
   logic [`UART_FIFO_DEPTH_LOG2-1:0]    wr_ptr;
   logic [`UART_FIFO_DEPTH_LOG2-1:0]    rd_ptr;
   uart_stream_pkg::fifo_count_t        count;
   logic                                push;
   logic                                pop;

   //////////////////////////////////////////////////////////////////////
   // handshake
   //////////////////////////////////////////////////////////////////////

   assign o_full       = (count == uart_stream_pkg::fifo_count_t'(`UART_FIFO_DEPTH));
   assign o_push_ready = !o_full;
   assign o_pop_valid  = (count != '0);
   assign o_pop_data   = mem[rd_ptr];

   assign push = i_push_valid && o_push_ready;
   assign pop  = o_pop_valid && i_pop_ready;

   //////////////////////////////////////////////////////////////////////
   // storage and pointers
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge i_clk) begin
      if (push) begin
         mem[wr_ptr] <= i_push_data;
      end
   end

   // pointers wrap on their own since the depth is a power of two
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + (`UART_FIFO_DEPTH_LOG2)'(1);
         end
         if (pop) begin
            rd_ptr <= rd_ptr + (`UART_FIFO_DEPTH_LOG2)'(1);
         end
      end
   end

   // occupancy, push and pop together leave it unchanged
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         count <= '0;
      end else begin
         case ({push, pop})
            2'b10:   count <= count + uart_stream_pkg::fifo_count_t'(1);
            2'b01:   count <= count - uart_stream_pkg::fifo_count_t'(1);
            default: count <= count;
         endcase
      end
   end

endmodule

// ==== verilog/uart_rx.sv ====
// 8N1 receiver at one fixed rate, no vote or break detect; a byte offered while not ready is lost
`timescale 1ns/10ps
`include "uart_defines.svh"

module uart_rx (
   input  logic                        i_clk,
   input  logic                        i_nrst,
   input  logic                        i_rx,
   output logic                        o_valid,
   output uart_stream_pkg::data_byte_t o_data,
   input  logic                        i_ready,
   output logic                        o_frame_err,
   output logic                        o_overrun
);

   uart_line_pkg::rx_state_e              state;
   logic [$clog2(`UART_CLKS_PER_BIT)-1:0] baud_cnt;
   logic [$clog2(`UART_CLKS_PER_BIT)-1:0] baud_next;
   logic [2:0]                            bit_idx;
   uart_stream_pkg::data_byte_t           shift_q;
   logic                                  rx_meta;
   logic                                  rx_sync;
   logic                                  rx_last;
   logic                                  rx_fall;
   logic                                  half_bit;
   logic                                  full_bit;
   logic                                  stop_sample;

   //////////////////////////////////////////////////////////////////////
   // input synchronizer and edge detect
   //////////////////////////////////////////////////////////////////////

   // line idles high, so the flops come out of reset high
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
         rx_last <= 1'b1;
      end else begin
         rx_meta <= i_rx;
         rx_sync <= rx_meta;
         rx_last <= rx_sync;
      end
   end

   assign rx_fall   = rx_last & ~rx_sync;
   assign baud_next = baud_cnt + ($clog2(`UART_CLKS_PER_BIT))'(1);
   assign half_bit  = (baud_cnt == ($clog2(`UART_CLKS_PER_BIT))'(`UART_CLKS_PER_BIT / 2 - 1));
   assign full_bit  = (baud_cnt == ($clog2(`UART_CLKS_PER_BIT))'(`UART_CLKS_PER_BIT - 1));

   //////////////////////////////////////////////////////////////////////
   // frame state machine
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state    <= uart_line_pkg::RX_IDLE;
         baud_cnt <= '0;
         bit_idx  <= '0;
      end else begin
         case (state)
            uart_line_pkg::RX_IDLE: begin
               baud_cnt <= '0;
               if (rx_fall) begin
                  state <= uart_line_pkg::RX_START;
               end
            end
            uart_line_pkg::RX_START: begin
               if (half_bit) begin
                  baud_cnt <= '0;
                  bit_idx  <= '0;
                  // start bit gone high again means a glitch, drop it quietly
                  state    <= rx_sync ? uart_line_pkg::RX_IDLE : uart_line_pkg::RX_DATA;
               end else begin
                  baud_cnt <= baud_next;
               end
            end
            uart_line_pkg::RX_DATA: begin
               if (full_bit) begin
                  baud_cnt <= '0;
                  if (bit_idx == 3'd7) begin
                     state <= uart_line_pkg::RX_STOP;
                  end else begin
                     bit_idx <= bit_idx + 3'd1;
                  end
               end else begin
                  baud_cnt <= baud_next;
               end
            end
            uart_line_pkg::RX_STOP: begin
               if (full_bit) begin
                  baud_cnt <= '0;
                  state    <= uart_line_pkg::RX_IDLE;
               end else begin
                  baud_cnt <= baud_next;
               end
            end
            default: state <= uart_line_pkg::RX_IDLE;
         endcase
      end
   end

   // data bits arrive lsb first, shift in from the top
   always_ff @(posedge i_clk) begin
      if ((state == uart_line_pkg::RX_DATA) && full_bit) begin
         shift_q <= {rx_sync, shift_q[7:1]};
      end
   end

   //////////////////////////////////////////////////////////////////////
   // stop bit decision
   //////////////////////////////////////////////////////////////////////

   assign stop_sample = (state == uart_line_pkg::RX_STOP) && full_bit;
   assign o_valid     = stop_sample && rx_sync;
   assign o_frame_err = stop_sample && !rx_sync;
   // the line cannot wait, so a refused byte is simply gone
   assign o_overrun   = o_valid && !i_ready;
   assign o_data      = shift_q;

endmodule

// ==== verilog/uart_stream_pkg.sv ====
// byte-stream types; the occupancy width follows the fifo depth from the defines header

`include "uart_defines.svh"

package uart_stream_pkg;

   //////////////////////////////////////////////////////////////////////
   // payload
   //////////////////////////////////////////////////////////////////////

   // one frame worth of data, lsb is the first bit on the wire
   typedef logic [7:0] data_byte_t;

   //////////////////////////////////////////////////////////////////////
   // buffer bookkeeping
   //////////////////////////////////////////////////////////////////////

   // one extra bit so a full fifo can be told apart from an empty one
   typedef logic [`UART_FIFO_DEPTH_LOG2:0] fifo_count_t;

endpackage

// ==== verilog/uart_line_pkg.sv ====
// serial-side types for an 8N1 line; no parity or break states exist in either machine

package uart_line_pkg;

   // receiver frame tracking
   typedef enum logic [1:0] {
      RX_IDLE,
      RX_START,
      RX_DATA,
      RX_STOP
   } rx_state_e;

   // transmitter frame tracking, same bit order as the receiver
   typedef enum logic [1:0] {
      TX_IDLE,
      TX_START,
      TX_DATA,
      TX_STOP
   } tx_state_e;

   // frame_err and overrun are single-cycle pulses, fifo_full is a level
   typedef struct packed {
      logic frame_err;
      logic overrun;
      logic fifo_full;
   } line_status_t;

endpackage

// ==== verilog/uart_defines.svh ====
// build-time constants only; clocks per bit must be 4 or more and even so mid-bit sampling holds
`ifndef UART_DEFINES_SVH
`define UART_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// serial line timing
//////////////////////////////////////////////////////////////////////

// system clocks per serial bit
`define UART_CLKS_PER_BIT 8

//////////////////////////////////////////////////////////////////////
// echo buffer sizing
//////////////////////////////////////////////////////////////////////

// fifo depth as a power of two
`define UART_FIFO_DEPTH_LOG2 3
`define UART_FIFO_DEPTH (1 << `UART_FIFO_DEPTH_LOG2)

`endif
